// ==== design/sfPkg.sv ====
// tile serializer shared definitions
package sfPkg;

   // ==============================
   // widths and timing
   // ==============================

   // bits per bitplane row
   localparam int planeWidth = 8;
   // system clocks per pixel enable, 48 MHz down to 6 MHz
   localparam int pixDiv = 8;
   localparam int paletteWidth = 3;
   localparam int colorIdxWidth = 2;

   // derived counter widths
   localparam int divWidth = $clog2(pixDiv);
   localparam int pixCntWidth = $clog2(planeWidth);

   // ==============================
   // enums
   // ==============================

   // encoded like the select pins of the universal shift register
   typedef enum logic [1:0] {
      modeHold  = 2'b00,
      modeShift = 2'b01,
      modeLoad  = 2'b11
   } shiftMode_e;

   typedef enum logic {
      stIdle  = 1'b0,
      stShift = 1'b1
   } serState_e;

   // ==============================
   // structs
   // ==============================

   // one tile row request
   typedef struct packed {
      logic [planeWidth-1:0]   plane0;
      logic [planeWidth-1:0]   plane1;
      logic                    flip;
      logic [paletteWidth-1:0] palette;
   } tileRow_t;

   // one outgoing pixel
   typedef struct packed {
      logic                     valid;
      logic [paletteWidth-1:0]  palette;
      logic [colorIdxWidth-1:0] colorIdx;
      logic                     opaque;
   } pixel_t;

endpackage

// ==== design/pixelTimer.sv ====
// pixel clock enable divider
module pixelTimer
   import sfPkg::*;
(
   input  logic clk,
   input  logic CR,
   input  logic clearCount_i,
   output logic pixEn_o,
   output logic lastPix_o
);

   logic [divWidth-1:0]    divCnt;
   logic [pixCntWidth-1:0] pixCnt;

   // free running divider, never stopped by the serializer
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         divCnt  <= '0;
         pixEn_o <= 1'b0;
      end
      else
      begin
         if (divCnt == divWidth'(pixDiv - 1))
            divCnt <= '0;
         else
            divCnt <= divCnt + 1'b1;
         // strobe lines up with the wrap of the divider
         pixEn_o <= (divCnt == divWidth'(pixDiv - 1));
      end
   end

   // pixels shifted so far in the current row
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         pixCnt <= '0;
      else if (clearCount_i)
         pixCnt <= '0;
      else if (pixEn_o)
         pixCnt <= pixCnt + 1'b1;
   end

   // enable that performs the eighth shift
   assign lastPix_o = pixEn_o && (pixCnt == pixCntWidth'(planeWidth - 1));

endmodule

// ==== design/serializerFsm.sv ====
// tile row sequencer
module serializerFsm
   import sfPkg::*;
(
   input  logic       clk,
   input  logic       CR,
   input  logic       tileReq_i,
   input  logic       pixEn_i,
   input  logic       lastPix_i,
   output shiftMode_e mode_o,
   output logic       clearCount_o,
   output logic       busy_o
);

   serState_e state;
   serState_e stateNext;
   logic      accept;

   // requests only count while idle, busy ones are dropped
   assign accept = (state == stIdle) && tileReq_i;

   // ==============================
   // state register
   // ==============================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         state <= stIdle;
      else
         state <= stateNext;
   end

   always_comb
   begin
      stateNext = state;
      case (state)
         stIdle:
         begin
            if (accept)
               stateNext = stShift;
         end
         stShift:
         begin
            // back to idle once the eighth pixel goes out
            if (lastPix_i)
               stateNext = stIdle;
         end
         default:
            stateNext = stIdle;
      endcase
   end

   // ==============================
   // outputs
   // ==============================

   always_comb
   begin
      mode_o = modeHold;
      if (accept)
         mode_o = modeLoad;
      else if ((state == stShift) && pixEn_i)
         mode_o = modeShift;
   end

   // restart pixel count with each new row
   assign clearCount_o = accept;
   assign busy_o = (state == stShift);

endmodule

// ==== design/planeShifter.sv ====
// bitplane shift register
module planeShifter
   import sfPkg::*;
(
   input  logic                  clk,
   input  logic                  CR,
   input  shiftMode_e            mode_i,
   input  logic [planeWidth-1:0] plane_i,
   input  logic                  flip_i,
   output logic                  outBit_o
);

   logic [planeWidth-1:0] shiftQ;
   // direction latched with the row
   logic                  flipQ;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         shiftQ <= '0;
         flipQ  <= 1'b0;
      end
      else
      begin
         case (mode_i)
            modeLoad:
            begin
               shiftQ <= plane_i;
               flipQ  <= flip_i;
            end
            modeShift:
            begin
               // zeros fill in behind, no serial input here
               if (flipQ)
                  shiftQ <= {1'b0, shiftQ[planeWidth-1:1]};
               else
                  shiftQ <= {shiftQ[planeWidth-2:0], 1'b0};
            end
            default:
               shiftQ <= shiftQ;
         endcase
      end
   end

   // output end follows the stored direction
   assign outBit_o = flipQ ? shiftQ[0] : shiftQ[planeWidth-1];

endmodule

// ==== design/pixelLatch.sv ====
// pixel output register
module pixelLatch
   import sfPkg::*;
(
   input  logic                    clk,
   input  logic                    CR,
   input  shiftMode_e              mode_i,
   input  logic [paletteWidth-1:0] palette_i,
   input  logic                    bit0_i,
   input  logic                    bit1_i,
   output pixel_t                  pix_o
);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         pix_o <= '0;
      else
      begin
         // valid is a one cycle pulse per shift
         pix_o.valid <= 1'b0;
         case (mode_i)
            modeLoad:
            begin
               // palette stays put for the whole row
               pix_o.palette <= palette_i;
            end
            modeShift:
            begin
               pix_o.valid    <= 1'b1;
               pix_o.colorIdx <= {bit1_i, bit0_i};
               // index zero is transparent
               pix_o.opaque   <= bit1_i | bit0_i;
            end
            default:
               pix_o.colorIdx <= pix_o.colorIdx;
         endcase
      end
   end

endmodule

// ==== design/tileSerializer.sv ====
// tile graphics serializer top
module tileSerializer
   import sfPkg::*;
(
   input  logic     clk,
   input  logic     CR,
   input  logic     tileReq_i,
   input  tileRow_t tile_i,
   output pixel_t   pix_o,
   output logic     busy_o,
   output logic     pixEn_o
);

   shiftMode_e mode;
   logic       clearCount;
   logic       lastPix;
   logic       outBit0;
   logic       outBit1;

   // ==============================
   // timing and control
   // ==============================

   pixelTimer i_pixelTimer (
      .clk          (clk),
      .CR           (CR),
      .clearCount_i (clearCount),
      .pixEn_o      (pixEn_o),
      .lastPix_o    (lastPix)
   );

   serializerFsm i_serializerFsm (
      .clk          (clk),
      .CR           (CR),
      .tileReq_i    (tileReq_i),
      .pixEn_i      (pixEn_o),
      .lastPix_i    (lastPix),
      .mode_o       (mode),
      .clearCount_o (clearCount),
      .busy_o       (busy_o)
   );

   // ==============================
   // datapath
   // ==============================

   // one shifter per bitplane
   planeShifter i_planeShifter0 (
      .clk      (clk),
      .CR       (CR),
      .mode_i   (mode),
      .plane_i  (tile_i.plane0),
      .flip_i   (tile_i.flip),
      .outBit_o (outBit0)
   );

   planeShifter i_planeShifter1 (
      .clk      (clk),
      .CR       (CR),
      .mode_i   (mode),
      .plane_i  (tile_i.plane1),
      .flip_i   (tile_i.flip),
      .outBit_o (outBit1)
   );

   pixelLatch i_pixelLatch (
      .clk       (clk),
      .CR        (CR),
      .mode_i    (mode),
      .palette_i (tile_i.palette),
      .bit0_i    (outBit0),
      .bit1_i    (outBit1),
      .pix_o     (pix_o)
   );

endmodule

// ==== dv/tileSerializer_props.sv ====
// tile serializer checkers
module tileSerializerProps
   import sfPkg::*;
(
   input logic     clk,
   input logic     CR,
   input logic     tileReq_i,
   input tileRow_t tile_i,
   input pixel_t   pix_o,
   input logic     busy_o,
   input logic     pixEn_o
);

   timeunit 1ns;
   timeprecision 100ps;

   tileRow_t modelRow;
   pixel_t   expPix;
   int       pixIdx;
   int       bitPos;
   int       enGap;
   int       validGap;
   logic     enSeen;
   int       errCount = 0;

   // ==============================
   // reference model
   // ==============================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         modelRow <= '0;
         pixIdx   <= 0;
         enGap    <= 0;
         validGap <= 0;
         enSeen   <= 1'b0;
      end
      else
      begin
         if (tileReq_i && !busy_o)
         begin
            modelRow <= tile_i;
            pixIdx   <= 0;
         end
         else if (pix_o.valid)
            pixIdx <= pixIdx + 1;
         if (pixEn_o)
         begin
            enGap  <= 1;
            enSeen <= 1'b1;
         end
         else
            enGap <= enGap + 1;
         validGap <= pix_o.valid ? 1 : validGap + 1;
      end
   end

   // pixel k takes bit k counted from the MSB unless flipped
   always_comb
   begin
      bitPos = (pixIdx < planeWidth) ? pixIdx : planeWidth - 1;
      if (!modelRow.flip)
         bitPos = planeWidth - 1 - bitPos;
      expPix.valid    = 1'b1;
      expPix.palette  = modelRow.palette;
      expPix.colorIdx = {modelRow.plane1[bitPos], modelRow.plane0[bitPos]};
      expPix.opaque   = (expPix.colorIdx != 2'b00);
   end

   // ==============================
   // assertions
   // ==============================

   // quiet in reset and in the first cycle after release
   resetQuiet: assert property (@(posedge clk)
      !CR || $past(!CR, 2) |-> !busy_o && !pix_o.valid && !pixEn_o)
   else
   begin
      $error("ERR t=%0t busy_o/pix_o.valid/pixEn_o exp=0 got=%0b%0b%0b", $time,
         $sampled(busy_o), $sampled(pix_o.valid), $sampled(pixEn_o));
      errCount++;
   end

   enPeriod: assert property (@(posedge clk) disable iff (!CR)
      pixEn_o && enSeen |-> enGap == pixDiv)
   else
   begin
      $error("ERR t=%0t pixEn_o gap exp=%0d got=%0d", $time, pixDiv, $sampled(enGap));
      errCount++;
   end

   validPeriod: assert property (@(posedge clk) disable iff (!CR)
      pix_o.valid && pixIdx > 0 |-> validGap == pixDiv)
   else
   begin
      $error("ERR t=%0t pix_o.valid gap exp=%0d got=%0d", $time, pixDiv,
         $sampled(validGap));
      errCount++;
   end

   pixValue: assert property (@(posedge clk) disable iff (!CR) pix_o.valid |-> pix_o == expPix)
   else
   begin
      $error("ERR t=%0t pix_o exp=%0h got=%0h", $time, $sampled(expPix), $sampled(pix_o));
      errCount++;
   end

   pixCount: assert property (@(posedge clk) disable iff (!CR)
      pix_o.valid |-> pixIdx < planeWidth)
   else
   begin
      $error("more than eight pixels came out of one tile row");
      errCount++;
   end

   tileEnd: assert property (@(posedge clk) disable iff (!CR)
      $fell(busy_o) |-> pix_o.valid && pixIdx == planeWidth - 1)
   else
   begin
      $error("busy_o fell without the eighth pixel at t=%0t", $time);
      errCount++;
   end

   opaqueFlag: assert property (@(posedge clk) disable iff (!CR)
      pix_o.valid |-> pix_o.opaque == (pix_o.colorIdx != 2'b00))
   else
   begin
      $error("ERR t=%0t pix_o.opaque exp=%0b got=%0b", $time,
         $sampled(pix_o.colorIdx != 2'b00), $sampled(pix_o.opaque));
      errCount++;
   end

   busyStart: assert property (@(posedge clk) disable iff (!CR)
      tileReq_i && !busy_o |=> busy_o)
   else
   begin
      $error("ERR t=%0t busy_o exp=1 got=%0b", $time, $sampled(busy_o));
      errCount++;
   end

endmodule

bind tileSerializer tileSerializerProps i_tileSerializerProps (.*);

// ==== dv/tileSerializerTb.sv ====
// tile serializer testbench
module tileSerializerTb
   import sfPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        CR;
   logic        tileReq;
   tileRow_t    tile;
   pixel_t      pix;
   logic        busy;
   logic        pixEn;
   logic [31:0] rngState;
   int          errs;

   // longest row is eight pixel periods plus the divider phase
   localparam int rowLimit = pixDiv * (planeWidth + 2) + 4;

   tileSerializer i_tileSerializer (
      .clk       (clk),
      .CR        (CR),
      .tileReq_i (tileReq),
      .tile_i    (tile),
      .pix_o     (pix),
      .busy_o    (busy),
      .pixEn_o   (pixEn)
   );

   // failure count kept by the bound checker
   assign errs = i_tileSerializer.i_tileSerializerProps.errCount;

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ==============================
   // helpers
   // ==============================

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic failRun();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped after a failure");
   endtask

   task automatic nextRow(output tileRow_t row);
      rngState = xorshift32(rngState);
      row.plane0  = rngState[7:0];
      row.plane1  = rngState[15:8];
      row.flip    = rngState[16];
      row.palette = rngState[19:17];
   endtask

   task automatic stepCycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   // poll busy_o once per cycle, shortly after the edge
   task automatic waitBusy(input logic level, input int limit);
      int n;
      n = 0;
      while (busy !== level)
      begin
         @(posedge clk);
         #1;
         n++;
         if (n > limit)
         begin
            $display("timeout: busy_o never reached %0b after %0d cycles", level, limit);
            failRun();
         end
      end
   endtask

   // one request strobe, then run the row to its end
   task automatic issueRow(input tileRow_t row, input bit intrude);
      tileRow_t other;
      waitBusy(1'b0, rowLimit);
      tile    = row;
      tileReq = 1'b1;
      stepCycles(1);
      tileReq = 1'b0;
      waitBusy(1'b1, 2);
      if (intrude)
      begin
         // a second request mid row must be dropped
         nextRow(other);
         stepCycles(pixDiv * 3 + 1);
         tile    = other;
         tileReq = 1'b1;
         stepCycles(1);
         tileReq = 1'b0;
      end
      waitBusy(1'b0, rowLimit);
   endtask

   // checker failures end the run at once
   initial
   begin
      forever
      begin
         @(posedge clk);
         #2;
         if (errs != 0)
            failRun();
      end
   end

   // ==============================
   // stimulus
   // ==============================

   initial
   begin
      tileRow_t row;
      CR       = 1'b0;
      tileReq  = 1'b0;
      tile     = '0;
      rngState = 32'd30;
      repeat (3) @(posedge clk);
      #1;
      CR = 1'b1;
      stepCycles(5);

      // transparent and solid rows, both directions
      issueRow('{plane0: 8'h00, plane1: 8'h00, flip: 1'b0, palette: 3'd2}, 1'b0);
      issueRow('{plane0: 8'hff, plane1: 8'hff, flip: 1'b0, palette: 3'd7}, 1'b0);
      issueRow('{plane0: 8'h00, plane1: 8'h00, flip: 1'b1, palette: 3'd5}, 1'b0);
      issueRow('{plane0: 8'hff, plane1: 8'hff, flip: 1'b1, palette: 3'd1}, 1'b0);

      for (int i = 0; i < 12; i++)
      begin
         nextRow(row);
         // same data once in each order
         row.flip = 1'b0;
         issueRow(row, 1'b0);
         row.flip = 1'b1;
         issueRow(row, 1'b0);
         stepCycles(rngState[22:20]);
      end

      for (int i = 0; i < 6; i++)
      begin
         nextRow(row);
         issueRow(row, 1'b1);
      end

      stepCycles(pixDiv * 2);
      if (errs == 0)
      begin
         $display("NO ERRORS");
         $finish;
      end
      else
         failRun();
   end

endmodule

// ==== build.f ====
design/sfPkg.sv
design/pixelTimer.sv
design/serializerFsm.sv
design/planeShifter.sv
design/pixelLatch.sv
design/tileSerializer.sv
dv/tileSerializer_props.sv
dv/tileSerializerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the tile serializer simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
   --top-module tileSerializerTb \
   -f build.f \
   -o VtileSerializerTb \
   && { ./obj_dir/VtileSerializerTb +verilator+error+limit+100 > "$LOG" 2>&1 || true; } \
   && cat "$LOG" \
   && ! grep -q "ERRORS FOUND" "$LOG" \
   && grep -q "NO ERRORS" "$LOG" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
